// ==== nvme_pkg.sv ====
package nvme_pkg;

  // NVMe command set constants used by the read path
  localparam logic [7:0]  NVME_OPC_READ = 8'h02;
  localparam logic [31:0] NVME_NSID     = 32'd1;

  // doorbells of the second queue pair, relative to BAR0
  localparam logic [33:0] SQ2TDBL_OFS = 34'h0_0000_1010;
  localparam logic [33:0] CQ2HDBL_OFS = 34'h0_0000_1014;

  localparam int unsigned SQ_ENTRY_BYTES = 64;
  localparam int unsigned CQ_ENTRY_BYTES = 16;

  // 64-byte submission entry, opcode ends up in bits 7:0
  typedef struct packed {
    logic [31:0]  cdw15;
    logic [31:0]  cdw14;
    logic [31:0]  cdw13;
    // nlb, zero based
    logic [31:0]  cdw12;
    // cdw10/11
    logic [63:0]  slba;
    logic [127:0] dptr;
    logic [63:0]  mptr;
    logic [63:0]  cdw2_3;
    logic [31:0]  nsid;
    logic [15:0]  cid;
    // fused op, psdt and reserved bits
    logic [7:0]   fuse_psdt;
    logic [7:0]   opcode;
  } nvme_sq_entry_t;

  // 16-byte completion entry, phase tag sits at bit 112
  typedef struct packed {
    logic [14:0] status;
    logic        phase;
    logic [15:0] cid;
    logic [15:0] sq_id;
    logic [15:0] sq_head;
    logic [31:0] dw1;
    logic [31:0] dw0;
  } nvme_cq_entry_t;

endpackage

// ==== drv_pkg.sv ====
package drv_pkg;

  // slots in flight on the read queue pair
  localparam int unsigned OUTSTANDING = 16;
  localparam int unsigned SLOT_W      = $clog2(OUTSTANDING);

  typedef logic [SLOT_W-1:0] slot_t;

  localparam int unsigned ADDR_W      = 34;
  localparam int unsigned HOST_ADDR_W = 48;

  // device-side memory map
  localparam logic [ADDR_W-1:0] RDSQ_BASE  = 34'h0_0060_0000;
  localparam logic [ADDR_W-1:0] RDBUF_BASE = 34'h0_0080_0000;
  localparam logic [ADDR_W-1:0] RDCQ_BASE  = 34'h0_00a0_0000;
  localparam logic [ADDR_W-1:0] NVME_BAR0  = 34'h3_8000_0000;

  // host register offsets
  localparam logic [3:0] CFG_WORD_SIZE_ADDR = 4'h0;
  localparam logic [3:0] CFG_BURST_LEN_ADDR = 4'h4;
  localparam logic [3:0] CFG_NLB_ADDR       = 4'h8;
  localparam logic [3:0] CFG_LBA_SIZE_ADDR  = 4'hc;

  typedef struct packed {
    logic [3:0]  word_size_log2;
    logic [7:0]  burst_len;
    logic [15:0] nlb;
    logic [3:0]  lba_size_log2;
  } drv_cfg_t;

  typedef struct packed {
    logic [ADDR_W-1:0]       addr;
    nvme_pkg::nvme_sq_entry_t entry;
  } sq_wr_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [31:0]       value;
  } db_wr_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } buf_rd_t;

endpackage

// ==== nvme_cfg_regs.sv ====
module nvme_cfg_regs (
  input  logic              clk,
  input  logic              rstn,
  input  logic              cfg_we,
  input  logic              cfg_re,
  input  logic [3:0]        cfg_addr,
  input  logic [31:0]       cfg_wdata,
  output logic [31:0]       cfg_rdata,
  output logic              cfg_rvalid,
  output drv_pkg::drv_cfg_t cfg
);

  import drv_pkg::*;

  logic [31:0] rd_mux;

  // write side, each field keeps only its own width
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg        <= '0;
      cfg_rvalid <= 1'b0;
    end else begin
      cfg_rvalid <= cfg_re;
      if (cfg_we) begin
        case (cfg_addr)
          CFG_WORD_SIZE_ADDR: cfg.word_size_log2 <= cfg_wdata[3:0];
          CFG_BURST_LEN_ADDR: cfg.burst_len      <= cfg_wdata[7:0];
          CFG_NLB_ADDR:       cfg.nlb            <= cfg_wdata[15:0];
          CFG_LBA_SIZE_ADDR:  cfg.lba_size_log2  <= cfg_wdata[3:0];
          default: begin
          end
        endcase
      end
    end
  end

  // read-back mux, unmapped offsets give zero
  always_comb begin
    case (cfg_addr)
      CFG_WORD_SIZE_ADDR: rd_mux = 32'(cfg.word_size_log2);
      CFG_BURST_LEN_ADDR: rd_mux = 32'(cfg.burst_len);
      CFG_NLB_ADDR:       rd_mux = 32'(cfg.nlb);
      CFG_LBA_SIZE_ADDR:  rd_mux = 32'(cfg.lba_size_log2);
      default:            rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (cfg_re) begin
      cfg_rdata <= rd_mux;
    end
  end

endmodule

// ==== sq_issuer.sv ====
module sq_issuer (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           req_valid,
  input  logic [drv_pkg::HOST_ADDR_W-1:0] req_addr,
  output logic                           req_ready,
  input  drv_pkg::drv_cfg_t              cfg,
  input  drv_pkg::slot_t                 sq_head,
  input  logic [drv_pkg::OUTSTANDING-1:0] cid_state,
  output logic                           sq_wr_valid,
  output drv_pkg::sq_wr_t                sq_wr,
  output logic                           sq_db_valid,
  output drv_pkg::db_wr_t                sq_db
);

  import nvme_pkg::*;
  import drv_pkg::*;

  slot_t                  tail;
  logic                   issue_phase;
  logic                   accept;
  slot_t                  wr_slot;
  nvme_sq_entry_t         cmd;
  logic [OUTSTANDING-1:0] cid_state_q;
  logic [OUTSTANDING-1:0] wr_busy;

  // slot must be completed in this lap and the ring must not fill up
  assign req_ready = (cid_state[tail] == issue_phase) &&
                     (slot_t'(tail + 1'b1) != sq_head);
  assign accept    = req_valid && req_ready;

  // READ command for the slot at tail
  always_comb begin
    cmd        = '0;
    cmd.opcode = NVME_OPC_READ;
    cmd.cid    = 16'(tail);
    cmd.nsid   = NVME_NSID;
    // PRP1 points at this slot's buffer region
    cmd.dptr   = 128'(RDBUF_BASE) + (128'(tail) << cfg.word_size_log2);
    cmd.slba   = 64'(req_addr >> cfg.lba_size_log2);
    cmd.cdw12  = 32'(cfg.nlb);
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      tail        <= '0;
      issue_phase <= 1'b0;
      sq_wr_valid <= 1'b0;
      sq_db_valid <= 1'b0;
    end else begin
      sq_wr_valid <= accept;
      // doorbell follows the entry write by one cycle
      sq_db_valid <= sq_wr_valid;
      if (accept) begin
        tail <= tail + 1'b1;
        if (tail == slot_t'(OUTSTANDING - 1)) begin
          issue_phase <= ~issue_phase;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_slot     <= tail;
      sq_wr.addr  <= RDSQ_BASE + ADDR_W'(tail) * ADDR_W'(SQ_ENTRY_BYTES);
      sq_wr.entry <= cmd;
    end
    if (sq_wr_valid) begin
      sq_db.addr  <= NVME_BAR0 + SQ2TDBL_OFS;
      sq_db.value <= 32'(slot_t'(wr_slot + 1'b1));
    end
  end

  // slots written to the SQ and not yet seen completing
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cid_state_q <= '0;
      wr_busy     <= '0;
    end else begin
      cid_state_q <= cid_state;
      // a completion flips the slot's bit
      wr_busy <= wr_busy & ~(cid_state ^ cid_state_q);
      if (sq_wr_valid) begin
        wr_busy[wr_slot] <= 1'b1;
      end
    end
  end

  // a slot is rewritten only after the poller has flipped its bit
  a_no_slot_reuse: assert property (
    @(posedge clk) disable iff (!rstn)
    sq_wr_valid |-> !wr_busy[wr_slot]
  ) else $error("sq entry written into slot %0d before it completed", wr_slot);

endmodule

// ==== cq_poller.sv ====
module cq_poller (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           db_rung,
  output logic                           cq_rd_valid,
  output logic [drv_pkg::ADDR_W-1:0]     cq_rd_addr,
  input  logic                           cq_rsp_valid,
  input  nvme_pkg::nvme_cq_entry_t       cq_rsp,
  output logic                           cq_db_valid,
  output drv_pkg::db_wr_t                cq_db,
  output drv_pkg::slot_t                 sq_head,
  output logic [drv_pkg::OUTSTANDING-1:0] cid_state
);

  import nvme_pkg::*;
  import drv_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    WAIT,
    DOORBELL
  } state_t;

  state_t            state;
  slot_t             head;
  logic              phase;
  logic [SLOT_W:0]   outstanding;
  logic              new_entry;
  slot_t             rsp_slot;

  // entry is new when its phase tag differs from the one we expect as stale
  assign new_entry = (state == WAIT) && cq_rsp_valid && (cq_rsp.phase != phase);
  assign rsp_slot  = cq_rsp.cid[SLOT_W-1:0];

  assign cq_rd_valid = (state == READ) && (outstanding != '0);
  assign cq_rd_addr  = RDCQ_BASE + ADDR_W'(head) * ADDR_W'(CQ_ENTRY_BYTES);

  // head has already advanced when the doorbell goes out
  assign cq_db_valid = (state == DOORBELL);
  assign cq_db.addr  = NVME_BAR0 + CQ2HDBL_OFS;
  assign cq_db.value = 32'(head);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= IDLE;
      head        <= '0;
      phase       <= 1'b0;
      outstanding <= '0;
      cid_state   <= '0;
      sq_head     <= '0;
    end else begin
      // commands rung but not yet seen in the CQ
      case ({db_rung, new_entry})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase

      case (state)
        IDLE: begin
          if (outstanding != '0) begin
            state <= READ;
          end
        end
        READ: begin
          state <= (outstanding != '0) ? WAIT : IDLE;
        end
        WAIT: begin
          if (cq_rsp_valid) begin
            // stale entry, poll the same slot again
            state <= new_entry ? DOORBELL : READ;
          end
          if (new_entry) begin
            head <= head + 1'b1;
            if (head == slot_t'(OUTSTANDING - 1)) begin
              phase <= ~phase;
            end
            cid_state[rsp_slot] <= ~cid_state[rsp_slot];
            sq_head             <= slot_t'(cq_rsp.sq_head);
          end
        end
        DOORBELL: begin
          state <= READ;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // device must not report more completions than commands rung
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rstn)
    new_entry |-> (outstanding != '0) || db_rung
  ) else $error("completion seen with no command outstanding");

endmodule

// ==== cpl_releaser.sv ====
module cpl_releaser (
  input  logic                           clk,
  input  logic                           rstn,
  input  drv_pkg::drv_cfg_t              cfg,
  input  logic [drv_pkg::OUTSTANDING-1:0] cid_state,
  output logic                           buf_rd_valid,
  output drv_pkg::buf_rd_t               buf_rd
);

  import drv_pkg::*;

  slot_t rel_idx;
  logic  rel_phase;
  logic  release_go;

  // next slot in order has completed in this lap
  assign release_go = (cid_state[rel_idx] != rel_phase);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rel_idx      <= '0;
      rel_phase    <= 1'b0;
      buf_rd_valid <= 1'b0;
    end else begin
      buf_rd_valid <= release_go;
      if (release_go) begin
        rel_idx <= rel_idx + 1'b1;
        if (rel_idx == slot_t'(OUTSTANDING - 1)) begin
          rel_phase <= ~rel_phase;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (release_go) begin
      buf_rd.addr <= RDBUF_BASE + (ADDR_W'(rel_idx) << cfg.word_size_log2);
      buf_rd.len  <= cfg.burst_len;
    end
  end

endmodule

// ==== nvme_rd_driver.sv ====
module nvme_rd_driver (
  input  logic                           clk,
  input  logic                           rstn,
  // host configuration port
  input  logic                           cfg_we,
  input  logic                           cfg_re,
  input  logic [3:0]                     cfg_addr,
  input  logic [31:0]                    cfg_wdata,
  output logic [31:0]                    cfg_rdata,
  output logic                           cfg_rvalid,
  // host read requests
  input  logic                           req_valid,
  input  logic [drv_pkg::HOST_ADDR_W-1:0] req_addr,
  output logic                           req_ready,
  // device side
  output logic                           sq_wr_valid,
  output drv_pkg::sq_wr_t                sq_wr,
  output logic                           sq_db_valid,
  output drv_pkg::db_wr_t                sq_db,
  output logic                           cq_rd_valid,
  output logic [drv_pkg::ADDR_W-1:0]     cq_rd_addr,
  input  logic                           cq_rsp_valid,
  input  nvme_pkg::nvme_cq_entry_t       cq_rsp,
  output logic                           cq_db_valid,
  output drv_pkg::db_wr_t                cq_db,
  output logic                           buf_rd_valid,
  output drv_pkg::buf_rd_t               buf_rd
);

  import drv_pkg::*;

  drv_cfg_t               cfg;
  slot_t                  sq_head;
  logic [OUTSTANDING-1:0] cid_state;

  nvme_cfg_regs cfg_regs_i (
    .clk        (clk),
    .rstn       (rstn),
    .cfg_we     (cfg_we),
    .cfg_re     (cfg_re),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rdata  (cfg_rdata),
    .cfg_rvalid (cfg_rvalid),
    .cfg        (cfg)
  );

  sq_issuer issuer_i (
    .clk         (clk),
    .rstn        (rstn),
    .req_valid   (req_valid),
    .req_addr    (req_addr),
    .req_ready   (req_ready),
    .cfg         (cfg),
    .sq_head     (sq_head),
    .cid_state   (cid_state),
    .sq_wr_valid (sq_wr_valid),
    .sq_wr       (sq_wr),
    .sq_db_valid (sq_db_valid),
    .sq_db       (sq_db)
  );

  // sq doorbell strobe doubles as the poller's db_rung
  cq_poller poller_i (
    .clk          (clk),
    .rstn         (rstn),
    .db_rung      (sq_db_valid),
    .cq_rd_valid  (cq_rd_valid),
    .cq_rd_addr   (cq_rd_addr),
    .cq_rsp_valid (cq_rsp_valid),
    .cq_rsp       (cq_rsp),
    .cq_db_valid  (cq_db_valid),
    .cq_db        (cq_db),
    .sq_head      (sq_head),
    .cid_state    (cid_state)
  );

  cpl_releaser releaser_i (
    .clk          (clk),
    .rstn         (rstn),
    .cfg          (cfg),
    .cid_state    (cid_state),
    .buf_rd_valid (buf_rd_valid),
    .buf_rd       (buf_rd)
  );

endmodule

// ==== tb_nvme_rd_driver.sv ====
module tb_nvme_rd_driver;
  timeunit 1ns;
  timeprecision 100ps;

  import nvme_pkg::*;
  import drv_pkg::*;

  logic                   clk = 1'b0;
  logic                   rstn;
  logic                   cfg_we, cfg_re, cfg_rvalid;
  logic [3:0]             cfg_addr;
  logic [31:0]            cfg_wdata, cfg_rdata;
  logic                   req_valid, req_ready;
  logic [HOST_ADDR_W-1:0] req_addr;
  logic                   sq_wr_valid, sq_db_valid, cq_rd_valid, cq_db_valid, buf_rd_valid;
  logic                   cq_rsp_valid = 1'b0;
  nvme_cq_entry_t         cq_rsp = '0;
  sq_wr_t                 sq_wr;
  db_wr_t                 sq_db, cq_db;
  logic [ADDR_W-1:0]      cq_rd_addr;
  buf_rd_t                buf_rd;

  // file contents and the expected configuration fields
  logic [3:0]             cfg_off[$];
  logic [31:0]            cfg_wd[$], cfg_exp[$];
  logic [HOST_ADDR_W-1:0] file_addr[$], acc_addr[$];
  int unsigned            cpl_order[$];
  int unsigned            hold_n = 0;
  logic [3:0]             exp_ws = '0, exp_lba = '0;
  logic [7:0]             exp_burst = '0;
  logic [15:0]            exp_nlb = '0;

  // scoreboard and CQ device model state
  int unsigned            cycles = 0, max_cycles = 100;
  int unsigned            wr_count = 0, db_count = 0, rel_count = 0, cpl_idx = 0;
  int unsigned            rsp_delay = 0, cq_db_due = 0;
  logic [OUTSTANDING-1:0] issued = '0, completed = '0;
  slot_t                  head_exp = '0;
  logic                   dev_phase = 1'b1;
  logic                   withhold = 1'b0;

  nvme_rd_driver dut_i (.*);

  always #2 clk = ~clk;

  task automatic abort(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      abort($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // read-back follows one cycle after the read strobe
  task automatic write_then_read(input logic [3:0] off, input logic [31:0] wdata,
                                 input logic [31:0] exp);
    cfg_we    = 1'b1;
    cfg_addr  = off;
    cfg_wdata = wdata;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    cfg_re = 1'b1;
    @(posedge clk);
    #1;
    cfg_re = 1'b0;
    check("cfg_rvalid", 128'(cfg_rvalid), 128'(1));
    check($sformatf("cfg_rdata at 0x%0h", off), 128'(cfg_rdata), 128'(exp));
  endtask

  // called 1 ns after an edge, returns at the same point after acceptance
  task automatic send_request(input logic [HOST_ADDR_W-1:0] addr);
    req_valid = 1'b1;
    req_addr  = addr;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    acc_addr.push_back(addr);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_releases(input int unsigned n);
    while (rel_count < n) begin
      @(posedge clk);
      #1;
    end
  endtask

  always @(posedge clk) begin
    slot_t          slot;
    nvme_cq_entry_t ent;
    cycles++;
    if (cycles > max_cycles) begin
      abort($sformatf("timeout, the run did not finish within %0d cycles", max_cycles));
    end
    if (rstn) begin
      if (sq_wr_valid) begin
        if (wr_count >= acc_addr.size()) begin
          abort("sq_wr strobe without an accepted request");
        end
        slot = slot_t'(wr_count);
        check("sq_wr.addr", 128'(sq_wr.addr), 128'(RDSQ_BASE) + (128'(slot) << 6));
        check("sq_wr.entry.opcode", 128'(sq_wr.entry.opcode), 128'(8'h02));
        check("sq_wr.entry.cid", 128'(sq_wr.entry.cid), 128'(slot));
        check("sq_wr.entry.nsid", 128'(sq_wr.entry.nsid), 128'(1));
        check("sq_wr.entry.dptr", sq_wr.entry.dptr, 128'(RDBUF_BASE) + (128'(slot) << exp_ws));
        check("sq_wr.entry.slba", 128'(sq_wr.entry.slba),
              128'(acc_addr[wr_count] >> exp_lba));
        check("sq_wr.entry.cdw12", 128'(sq_wr.entry.cdw12), 128'(exp_nlb));
        check("sq_wr.entry.mptr_cdw2_3", {sq_wr.entry.mptr, sq_wr.entry.cdw2_3}, '0);
        check("sq_wr.entry.cdw13_15_fuse", 128'({sq_wr.entry.cdw15, sq_wr.entry.cdw14,
              sq_wr.entry.cdw13, sq_wr.entry.fuse_psdt}), '0);
        wr_count++;
      end
      if (sq_db_valid) begin
        slot = slot_t'(db_count);
        check("sq_db.addr", 128'(sq_db.addr), 128'(NVME_BAR0) + 128'(34'h1010));
        check("sq_db.value", 128'(sq_db.value), 128'((db_count + 1) % 16));
        issued[slot] = 1'b1;
        db_count++;
      end
      // head moves only when the model has handed out a new entry
      if (cq_rd_valid) begin
        check("cq_rd_addr", 128'(cq_rd_addr), 128'(RDCQ_BASE) + (128'(head_exp) << 4));
        if (rsp_delay != 0) begin
          abort("cq_rd issued while a CQ read was still pending");
        end
        rsp_delay = 1 + $urandom % 6;
      end
      if (cq_db_valid) begin
        if (cq_db_due == 0) begin
          abort("cq_db written without a new CQ entry");
        end
        check("cq_db.addr", 128'(cq_db.addr), 128'(NVME_BAR0) + 128'(34'h1014));
        check("cq_db.value", 128'(cq_db.value), 128'(head_exp));
        cq_db_due--;
      end
      if (buf_rd_valid) begin
        slot = slot_t'(rel_count);
        if (!completed[slot]) begin
          abort($sformatf("buf_rd for slot %0d came before its completion", slot));
        end
        check("buf_rd.addr", 128'(buf_rd.addr), 128'(RDBUF_BASE) + (128'(slot) << exp_ws));
        check("buf_rd.len", 128'(buf_rd.len), 128'(exp_burst));
        completed[slot] = 1'b0;
        rel_count++;
      end
    end
    // CQ device model, answers drive 1 ns after the edge
    #1;
    cq_rsp_valid = 1'b0;
    if (rsp_delay != 0) begin
      rsp_delay--;
      if (rsp_delay == 0) begin
        ent       = '0;
        ent.sq_id = 16'd2;
        ent.phase = ~dev_phase;
        if (!withhold && cpl_idx < cpl_order.size()) begin
          slot = slot_t'(cpl_order[cpl_idx]);
          if (issued[slot]) begin
            issued[slot]    = 1'b0;
            completed[slot] = 1'b1;
            cpl_idx++;
            ent.phase   = dev_phase;
            ent.cid     = 16'(slot);
            ent.sq_head = 16'(cpl_idx % 16);
            head_exp    = head_exp + 1'b1;
            if (head_exp == '0) begin
              dev_phase = ~dev_phase;
            end
            cq_db_due++;
          end
        end
        cq_rsp       = ent;
        cq_rsp_valid = 1'b1;
      end
    end
  end

  initial begin
    int                     fd;
    int unsigned            n;
    int unsigned            v;
    int unsigned            total;
    string                  kw;
    string                  line;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [31:0]            c;
    logic [HOST_ADDR_W-1:0] addr;
    rstn      = 1'b0;
    cfg_we    = 1'b0;
    cfg_re    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    req_valid = 1'b0;
    req_addr  = '0;
    void'($urandom(88020));

    fd = $fopen("rd_stimulus.txt", "r");
    if (fd == 0) begin
      abort("cannot open rd_stimulus.txt");
    end
    while ($fscanf(fd, "%s", kw) == 1) begin
      if (kw.substr(0, 0) == "#") begin
        void'($fgets(line, fd));
      end else if (kw == "cfg") begin
        if ($fscanf(fd, "%h %h %h", a, b, c) != 3) begin
          abort("malformed cfg line in rd_stimulus.txt");
        end
        cfg_off.push_back(a[3:0]);
        cfg_wd.push_back(b);
        cfg_exp.push_back(c);
      end else if (kw == "req") begin
        void'($fscanf(fd, "%d", n));
        repeat (n) begin
          void'($fscanf(fd, "%h", addr));
          file_addr.push_back(addr);
        end
      end else if (kw == "cpl") begin
        void'($fscanf(fd, "%d", n));
        repeat (n) begin
          void'($fscanf(fd, "%d", v));
          cpl_order.push_back(v);
        end
      end else if (kw == "hold") begin
        void'($fscanf(fd, "%d", hold_n));
      end else begin
        abort($sformatf("unknown keyword %s in rd_stimulus.txt", kw));
      end
    end
    $fclose(fd);
    total = file_addr.size() + hold_n;
    if (cpl_order.size() != total) begin
      abort("completion order does not cover every request in rd_stimulus.txt");
    end
    max_cycles = 200 * total + 100;

    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    check("req_ready after reset", 128'(req_ready), 128'(1));
    check("strobes after reset", 128'({sq_wr_valid, sq_db_valid, cq_rd_valid, cq_db_valid,
          buf_rd_valid, cfg_rvalid}), '0);

    foreach (cfg_off[i]) begin
      write_then_read(cfg_off[i], cfg_wd[i], cfg_exp[i]);
      case (cfg_off[i])
        4'h0: exp_ws = cfg_exp[i][3:0];
        4'h4: exp_burst = cfg_exp[i][7:0];
        4'h8: exp_nlb = cfg_exp[i][15:0];
        4'hc: exp_lba = cfg_exp[i][3:0];
        default: begin
        end
      endcase
    end

    // out-of-order completions, releases must stay in slot order
    foreach (file_addr[i]) begin
      send_request(file_addr[i]);
    end
    wait_releases(file_addr.size());

    // fill the ring with completions held back
    @(posedge clk);
    withhold = 1'b1;
    #1;
    repeat (hold_n) begin
      check("req_ready before full", 128'(req_ready), 128'(1));
      send_request({16'($urandom), $urandom});
    end
    repeat (20) begin
      check("req_ready while full", 128'(req_ready), 128'(0));
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    withhold = 1'b0;
    n = cpl_idx;
    while (cpl_idx == n) begin
      @(posedge clk);
    end
    #1;
    check("req_ready after sq_head moved", 128'(req_ready), 128'(1));

    wait_releases(total);
    repeat (2) @(posedge clk);
    #1;
    if (cpl_idx == total && db_count == total && cq_db_due == 0 && completed == '0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      abort("run ended with commands or doorbells still outstanding");
    end
  end

endmodule

// ==== rd_stimulus.txt ====
# cfg <offset> <write data> <expected read-back>, all hex
# req <n> then n host byte addresses in hex, cpl <n> then n cids in decimal, hold <accepted>
cfg 0 0000001c 0000000c
cfg 4 00000140 00000040
cfg 8 abcd0007 00000007
cfg c ffffff39 00000009
cfg 2 deadbeef 00000000
cfg 7 12345678 00000000
req 6
000000001200
123456789a00
00000003fe00
0000dead0200
7ffffffff000
000000000000
cpl 6
2 0 1 5 3 4
# order for the hold phase, slots 6 to 15 then 0 to 4
cpl 15
7 6 9 8 11 10 13 12 15 14 1 0 3 2 4
hold 15

// ==== tb.f ====
nvme_pkg.sv
drv_pkg.sv
nvme_cfg_regs.sv
sq_issuer.sv
cq_poller.sv
cpl_releaser.sv
nvme_rd_driver.sv
tb_nvme_rd_driver.sv

// ==== Makefile ====
TOP = tb_nvme_rd_driver

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f tb.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -x ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
